// File: bench/isqrt_input.txt
// Columns: input x, expected 1/sqrt(x) as Q1.15, both in hex
// Zero input saturates to all ones
0000 ffff
0001 7fff
0002 5a82
0003 49e7
0004 3fff
0008 2d41
0010 1fff
0064 0ccc
0100 07ff
0400 03ff
03e8 040c
ffff 0080

// File: bench/isqrt_tb.sv
`timescale 1ns/10ps
`default_nettype none

module isqrt_tb;

    localparam int NUM_VECTORS = 12;
    localparam int TIMEOUT     = 200;
    localparam int LATENCY     = 11;

    logic                clk;
    logic                arst_n;
    isqrt_pkg::in_word_t in_x;
    logic                in_valid;
    logic                in_ready;
    isqrt_pkg::frac_t    out_y;
    logic                out_valid;
    logic                out_ready = 1'b0;

    // Even entries hold x, odd entries the expected result
    logic [15:0]         vec_mem [2*NUM_VECTORS];
    isqrt_pkg::in_word_t issued_x [$];
    isqrt_pkg::frac_t    expected_y [$];
    logic [31:0]         lcg_state = 32'hfb01;
    logic                stall_on;
    int                  results_seen = 0;
    int                  value_errors = 0;
    int                  timeout_errors = 0;
    int                  other_errors = 0;

    isqrt_top isqrt_top_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_x     (in_x),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_y    (out_y),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic end_run();
        $display("Errors: %0d value, %0d timeout, %0d other",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Truncation in three multiplies may cost up to two LSB
    task automatic check_result(input isqrt_pkg::in_word_t x, input isqrt_pkg::frac_t got,
                                input isqrt_pkg::frac_t exp);
        int diff;
        diff = int'(got) - int'(exp);
        if ($isunknown(got) || diff > 2 || diff < -2) begin
            $display("CHECK FAILED out_y for x=0x%04h: got 0x%04h, expected 0x%04h",
                     x, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    // Holds in_valid until the DUT takes the item
    task automatic send_item(input isqrt_pkg::in_word_t x, input isqrt_pkg::frac_t y);
        int waited;
        waited = 0;
        in_x     <= x;
        in_valid <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            if (waited >= TIMEOUT) begin
                $display("Timeout: in_ready stayed low for %0d cycles", TIMEOUT);
                timeout_errors++;
                end_run();
            end
            @(posedge clk);
        end
        issued_x.push_back(x);
        expected_y.push_back(y);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_y.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited >= TIMEOUT) begin
                $display("Timeout: %0d results never came out", expected_y.size());
                timeout_errors++;
                end_run();
            end
        end
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        lcg_state <= lcg_next(lcg_state);
        out_ready <= stall_on ? lcg_state[16] : 1'b1;
    end

    // Results must come out in issue order
    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            results_seen++;
            if (expected_y.size() == 0) begin
                $display("Output 0x%04h appeared with no input in flight", out_y);
                other_errors++;
            end else begin
                check_result(issued_x.pop_front(), out_y, expected_y.pop_front());
            end
        end
    end

    initial begin
        int cycles;
        arst_n   = 1'b0;
        in_x     = '0;
        in_valid = 1'b0;
        stall_on = 1'b0;
        $readmemh("bench/isqrt_input.txt", vec_mem);
        if ($isunknown(vec_mem[2*NUM_VECTORS-1])) begin
            $display("Vector file bench/isqrt_input.txt is missing or too short");
            other_errors++;
            end_run();
        end

        repeat (16) begin
            @(posedge clk);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_ready", in_ready, 1'b1);
        end
        arst_n <= 1'b1;
        @(posedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        // Back-to-back stream under random stalls
        stall_on <= 1'b1;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            send_item(vec_mem[2*i], vec_mem[2*i+1]);
        end
        in_valid <= 1'b0;
        wait_drain();
        check_count("result_count", results_seen, NUM_VECTORS);

        // Single item through an idle pipe
        stall_on <= 1'b0;
        repeat (2) @(posedge clk);
        send_item(vec_mem[4], vec_mem[5]);
        in_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!out_valid && cycles < TIMEOUT);
        if (!out_valid) begin
            $display("Timeout: out_valid never rose for the single item");
            timeout_errors++;
            end_run();
        end
        check_count("latency", cycles, LATENCY);
        wait_drain();
        check_count("result_count", results_seen, NUM_VECTORS + 1);
        end_run();
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/isqrt_pkg.sv
rtl/skid_buffer.sv
rtl/range_reduce.sv
rtl/seed_lut.sv
rtl/fixed_nr_stage.sv
rtl/denormalize.sv
rtl/isqrt_top.sv
bench/isqrt_tb.sv

// File: rtl/denormalize.sv
`timescale 1ns/10ps
`default_nettype none

`include "isqrt_config.svh"

module denormalize (
    input  logic             clk,
    input  logic             arst_n,
    input  isqrt_pkg::frac_t y,
    input  isqrt_pkg::side_t side,
    input  logic             in_valid,
    output logic             in_ready,
    output isqrt_pkg::frac_t result,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int W = `ISQRT_FRAC_WIDTH;

    // sqrt(1/2) in Q1.(W-1), truncated
    localparam isqrt_pkg::frac_t SQRT_HALF =
        isqrt_pkg::frac_t'($rtoi(0.70710678118654752 * (2.0 ** (W - 1))));

    isqrt_pkg::wide_t   prod;
    isqrt_pkg::frac_t   scaled;
    isqrt_pkg::out_pl_t pl_d;
    isqrt_pkg::out_pl_t pl_q;

    // 1/sqrt(x) = 1/sqrt(m) * 2^(-exp/2)
    always_comb begin
        prod   = (isqrt_pkg::wide_t'(y) * SQRT_HALF) >> (W - 1);
        // Odd exponent leaves a half power of two behind
        scaled = side.exp[0] ? prod[W-1:0] : y;
        if (side.zero) begin
            pl_d.result = '1;
        end else begin
            pl_d.result = scaled >> (side.exp >> 1);
        end
    end

    skid_buffer #(
        .payload_t(isqrt_pkg::out_pl_t)
    ) out_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       (pl_d),
        .data_in_valid (in_valid),
        .data_in_ready (in_ready),
        .data_out      (pl_q),
        .data_out_valid(out_valid),
        .data_out_ready(out_ready)
    );

    assign result = pl_q.result;

endmodule

`default_nettype wire

// File: rtl/fixed_nr_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "isqrt_config.svh"

module fixed_nr_stage (
    input  logic             clk,
    input  logic             arst_n,
    // Reduced input m in Q1.15
    input  isqrt_pkg::frac_t data_a,
    // Current guess y in Q1.15
    input  isqrt_pkg::frac_t data_b,
    input  isqrt_pkg::side_t data_in_msb,
    input  logic             data_in_valid,
    output logic             data_in_ready,
    output isqrt_pkg::wide_t data_out,
    output isqrt_pkg::side_t data_out_msb,
    output isqrt_pkg::frac_t data_out_x_reduced,
    output logic             data_out_valid,
    input  logic             data_out_ready
);

    localparam int W = `ISQRT_FRAC_WIDTH;
    localparam int N_REGS = 4;

    // 1.5 in Q1.(W-1)
    localparam isqrt_pkg::wide_t THREEHALFS = isqrt_pkg::wide_t'(3) << (W - 2);

    isqrt_pkg::nr_pl_t stage_d [N_REGS];
    isqrt_pkg::nr_pl_t stage_q [N_REGS];
    logic              pipe_valid [N_REGS+1];
    logic              pipe_ready [N_REGS+1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // y * (1.5 - (m/2) * y^2), one operation per register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // y^2
        stage_d[0].acc   = (isqrt_pkg::wide_t'(data_b) * data_b) >> (W - 1);
        stage_d[0].guess = data_b;
        stage_d[0].mant  = data_a;
        stage_d[0].side  = data_in_msb;

        // (m/2) * y^2
        stage_d[1]     = stage_q[0];
        stage_d[1].acc = (isqrt_pkg::wide_t'(stage_q[0].mant >> 1) * stage_q[0].acc)
                         >> (W - 1);

        stage_d[2]     = stage_q[1];
        stage_d[2].acc = THREEHALFS - stage_q[1].acc;

        // Refined guess
        stage_d[3]     = stage_q[2];
        stage_d[3].acc = (isqrt_pkg::wide_t'(stage_q[2].guess) * stage_q[2].acc)
                         >> (W - 1);
    end

    assign pipe_valid[0]      = data_in_valid;
    assign data_in_ready      = pipe_ready[0];
    assign pipe_ready[N_REGS] = data_out_ready;
    assign data_out_valid     = pipe_valid[N_REGS];

    for (genvar k = 0; k < N_REGS; k++) begin : g_pipe
        skid_buffer #(
            .payload_t(isqrt_pkg::nr_pl_t)
        ) pipe_reg (
            .clk           (clk),
            .arst_n        (arst_n),
            .data_in       (stage_d[k]),
            .data_in_valid (pipe_valid[k]),
            .data_in_ready (pipe_ready[k]),
            .data_out      (stage_q[k]),
            .data_out_valid(pipe_valid[k+1]),
            .data_out_ready(pipe_ready[k+1])
        );
    end

    assign data_out           = stage_q[N_REGS-1].acc;
    assign data_out_x_reduced = stage_q[N_REGS-1].mant;
    assign data_out_msb       = stage_q[N_REGS-1].side;

endmodule

`default_nettype wire

// File: rtl/isqrt_config.svh
`ifndef ISQRT_CONFIG_SVH
`define ISQRT_CONFIG_SVH

// Unsigned integer input
`define ISQRT_IN_WIDTH 16

// Q1.(W-1) word used for mantissa, guess and result
`define ISQRT_FRAC_WIDTH 16

// Mantissa bits below the leading one that index the seed table
`define ISQRT_LUT_BITS 6

// Newton-Raphson steps in series
`define ISQRT_NR_STAGES 2

// Wide enough to hold ISQRT_IN_WIDTH itself
`define ISQRT_EXP_WIDTH 5

`endif

// File: rtl/isqrt_pkg.sv
`default_nettype none

`include "isqrt_config.svh"

package isqrt_pkg;

    typedef logic [`ISQRT_IN_WIDTH-1:0] in_word_t;
    typedef logic [`ISQRT_FRAC_WIDTH-1:0] frac_t;
    typedef logic [2*`ISQRT_FRAC_WIDTH-1:0] wide_t;
    typedef logic [`ISQRT_EXP_WIDTH-1:0] exp_t;

    // Travels with every item down the pipe
    typedef struct packed {
        exp_t exp;
        logic zero;
    } side_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register slice payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        frac_t mant;
        side_t side;
    } reduce_pl_t;

    typedef struct packed {
        frac_t mant;
        frac_t guess;
        side_t side;
    } seed_pl_t;

    // acc holds the partial NR result of the current step
    typedef struct packed {
        wide_t acc;
        frac_t guess;
        frac_t mant;
        side_t side;
    } nr_pl_t;

    typedef struct packed {
        frac_t result;
    } out_pl_t;

endpackage

`default_nettype wire

// File: rtl/isqrt_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "isqrt_config.svh"

module isqrt_top (
    input  logic                clk,
    input  logic                arst_n,
    input  isqrt_pkg::in_word_t in_x,
    input  logic                in_valid,
    output logic                in_ready,
    output isqrt_pkg::frac_t    out_y,
    output logic                out_valid,
    input  logic                out_ready
);

    localparam int W  = `ISQRT_FRAC_WIDTH;
    localparam int NR = `ISQRT_NR_STAGES;

    isqrt_pkg::frac_t red_mant;
    isqrt_pkg::side_t red_side;
    logic             red_valid;
    logic             red_ready;

    // Index k is the input of refinement stage k, index NR feeds denormalize
    isqrt_pkg::frac_t nr_mant  [NR+1];
    isqrt_pkg::frac_t nr_guess [NR+1];
    isqrt_pkg::side_t nr_side  [NR+1];
    logic             nr_valid [NR+1];
    logic             nr_ready [NR+1];
    isqrt_pkg::wide_t nr_out   [NR];

    range_reduce range_reduce_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .x         (in_x),
        .x_valid   (in_valid),
        .x_ready   (in_ready),
        .mant      (red_mant),
        .side      (red_side),
        .mant_valid(red_valid),
        .mant_ready(red_ready)
    );

    seed_lut seed_lut_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .mant     (red_mant),
        .side     (red_side),
        .in_valid (red_valid),
        .in_ready (red_ready),
        .mant_out (nr_mant[0]),
        .guess    (nr_guess[0]),
        .side_out (nr_side[0]),
        .out_valid(nr_valid[0]),
        .out_ready(nr_ready[0])
    );

    for (genvar k = 0; k < NR; k++) begin : g_nr
        fixed_nr_stage nr_stage_inst (
            .clk               (clk),
            .arst_n            (arst_n),
            .data_a            (nr_mant[k]),
            .data_b            (nr_guess[k]),
            .data_in_msb       (nr_side[k]),
            .data_in_valid     (nr_valid[k]),
            .data_in_ready     (nr_ready[k]),
            .data_out          (nr_out[k]),
            .data_out_msb      (nr_side[k+1]),
            .data_out_x_reduced(nr_mant[k+1]),
            .data_out_valid    (nr_valid[k+1]),
            .data_out_ready    (nr_ready[k+1])
        );

        // Refined value stays below 2, the low word holds all of it
        assign nr_guess[k+1] = nr_out[k][W-1:0];
    end

    denormalize denormalize_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .y        (nr_guess[NR]),
        .side     (nr_side[NR]),
        .in_valid (nr_valid[NR]),
        .in_ready (nr_ready[NR]),
        .result   (out_y),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// File: rtl/range_reduce.sv
`timescale 1ns/10ps
`default_nettype none

`include "isqrt_config.svh"

module range_reduce (
    input  logic                clk,
    input  logic                arst_n,
    input  isqrt_pkg::in_word_t x,
    input  logic                x_valid,
    output logic                x_ready,
    output isqrt_pkg::frac_t    mant,
    output isqrt_pkg::side_t    side,
    output logic                mant_valid,
    input  logic                mant_ready
);

    localparam int IN_W   = `ISQRT_IN_WIDTH;
    localparam int FRAC_W = `ISQRT_FRAC_WIDTH;

    // 0.5 in Q1.(FRAC_W-1)
    localparam isqrt_pkg::frac_t HALF = isqrt_pkg::frac_t'(1) << (FRAC_W - 2);

    // Returns IN_W for a zero word
    function automatic int count_lz(input isqrt_pkg::in_word_t v);
        int   n;
        logic found;
        n     = 0;
        found = 1'b0;
        for (int i = IN_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n++;
            end
        end
        return n;
    endfunction

    int                    lz;
    isqrt_pkg::in_word_t   x_norm;
    logic [IN_W+FRAC_W-1:0] x_ext;
    isqrt_pkg::reduce_pl_t pl_d;
    isqrt_pkg::reduce_pl_t pl_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Normalize so that x = m * 2^exp with m in [0.5, 1)
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        lz     = count_lz(x);
        x_norm = x << lz;
        // Leading one moves from bit IN_W-1 to the 0.5 weight
        x_ext  = {x_norm, {FRAC_W{1'b0}}} >> (IN_W + 1);

        pl_d.side.zero = (x == '0);
        pl_d.side.exp  = isqrt_pkg::exp_t'(IN_W - lz);
        // Zero input still hands a legal mantissa downstream
        pl_d.mant      = pl_d.side.zero ? HALF : x_ext[FRAC_W-1:0];
    end

    skid_buffer #(
        .payload_t(isqrt_pkg::reduce_pl_t)
    ) reduce_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       (pl_d),
        .data_in_valid (x_valid),
        .data_in_ready (x_ready),
        .data_out      (pl_q),
        .data_out_valid(mant_valid),
        .data_out_ready(mant_ready)
    );

    assign mant = pl_q.mant;
    assign side = pl_q.side;

endmodule

`default_nettype wire

// File: rtl/seed_lut.sv
`timescale 1ns/10ps
`default_nettype none

`include "isqrt_config.svh"

module seed_lut (
    input  logic             clk,
    input  logic             arst_n,
    input  isqrt_pkg::frac_t mant,
    input  isqrt_pkg::side_t side,
    input  logic             in_valid,
    output logic             in_ready,
    output isqrt_pkg::frac_t mant_out,
    output isqrt_pkg::frac_t guess,
    output isqrt_pkg::side_t side_out,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int FRAC_W   = `ISQRT_FRAC_WIDTH;
    localparam int LUT_BITS = `ISQRT_LUT_BITS;
    localparam int LUT_SIZE = 1 << LUT_BITS;

    typedef isqrt_pkg::frac_t seed_table_t [LUT_SIZE];

    function automatic logic [63:0] int_sqrt(input logic [63:0] n);
        logic [63:0] r;
        logic [63:0] b;
        r = '0;
        for (int k = 31; k >= 0; k--) begin
            b = r | (64'd1 << k);
            if (b * b <= n) begin
                r = b;
            end
        end
        return r;
    endfunction

    // Entry i is 1/sqrt of the midpoint (2^(L+1) + 2i + 1) / 2^(L+2)
    function automatic seed_table_t build_table();
        seed_table_t tab;
        logic [63:0] num;
        logic [63:0] den;
        num = 64'd1 << (2 * (FRAC_W - 1) + LUT_BITS + 2);
        for (int i = 0; i < LUT_SIZE; i++) begin
            den    = 64'((1 << (LUT_BITS + 1)) + 2 * i + 1);
            tab[i] = isqrt_pkg::frac_t'(int_sqrt(num / den));
        end
        return tab;
    endfunction

    localparam seed_table_t SEED_TABLE = build_table();

    isqrt_pkg::seed_pl_t pl_d;
    isqrt_pkg::seed_pl_t pl_q;

    // Index with the bits just below the leading one at FRAC_W-2
    assign pl_d.guess = SEED_TABLE[mant[FRAC_W-3 -: LUT_BITS]];
    assign pl_d.mant  = mant;
    assign pl_d.side  = side;

    skid_buffer #(
        .payload_t(isqrt_pkg::seed_pl_t)
    ) seed_reg (
        .clk           (clk),
        .arst_n        (arst_n),
        .data_in       (pl_d),
        .data_in_valid (in_valid),
        .data_in_ready (in_ready),
        .data_out      (pl_q),
        .data_out_valid(out_valid),
        .data_out_ready(out_ready)
    );

    assign mant_out = pl_q.mant;
    assign guess    = pl_q.guess;
    assign side_out = pl_q.side;

endmodule

`default_nettype wire

// File: rtl/skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t data_in,
    input  logic     data_in_valid,
    output logic     data_in_ready,
    output payload_t data_out,
    output logic     data_out_valid,
    input  logic     data_out_ready
);

    payload_t main_data;
    payload_t skid_data;
    logic     main_valid;
    logic     skid_valid;
    logic     main_take;

    // Main register can accept a new item this cycle
    assign main_take = !main_valid || data_out_ready;

    // Registered, so upstream ready never sees downstream ready
    assign data_in_ready = !skid_valid;

    assign data_out       = main_data;
    assign data_out_valid = main_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_take) begin
            main_valid <= skid_valid || data_in_valid;
            skid_valid <= 1'b0;
        end else if (data_in_valid && !skid_valid) begin
            // Output stalled, park the incoming item
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_take) begin
            main_data <= skid_valid ? skid_data : data_in;
        end
        if (!skid_valid) begin
            skid_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module isqrt_tb -o isqrt_sim
./obj_dir/isqrt_sim | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
